//--- include/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// operand and result width in bits
`define EXEC_XLEN 32

// width of the tag echoed back with each result
`define EXEC_TAG_W 4

// queue slots, equal to the credits upstream starts with
`define EXEC_QUEUE_DEPTH 4

// one multiply or divide iteration per operand bit
`define EXEC_MULDIV_STEPS 32

`endif

//--- design/exec_pkg.sv
`default_nettype none
`include "exec_consts.svh"

package exec_pkg;

	typedef logic [`EXEC_XLEN-1:0] word_t;
	typedef logic [$clog2(`EXEC_XLEN)-1:0] shamt_t;
	typedef logic [`EXEC_TAG_W-1:0] tag_t;

	// muldiv codes sit at the top
	typedef enum logic [4:0] {
		OP_AND   = 5'b00000,
		OP_OR    = 5'b00001,
		OP_XOR   = 5'b00010,
		OP_ADD   = 5'b00011,
		OP_SUB   = 5'b00100,
		OP_SLTU  = 5'b00101,
		OP_SLT   = 5'b00110,
		OP_LUI   = 5'b00111,
		OP_SLL   = 5'b01000,
		OP_SRL   = 5'b01001,
		OP_SRA   = 5'b01010,
		OP_SLLV  = 5'b01011,
		OP_SRLV  = 5'b01100,
		OP_SRAV  = 5'b01101,
		OP_BEQ   = 5'b01110,
		OP_BNE   = 5'b01111,
		OP_BGEZ  = 5'b10000,
		OP_BGTZ  = 5'b10001,
		OP_BLEZ  = 5'b10010,
		OP_BLTZ  = 5'b10011,
		OP_MULTU = 5'b10100,
		OP_DIVU  = 5'b10101,
		OP_MFHI  = 5'b10110,
		OP_MFLO  = 5'b10111
	} alu_op_t;

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_RUN,
		MD_FINISH
	} muldiv_state_t;

	typedef struct packed {
		alu_op_t op;
		word_t   a;
		word_t   b;
		shamt_t  shamt;	// immediate shift amount
		tag_t    tag;
	} exec_op_t;

	typedef struct packed {
		word_t value;
		logic  zero;
		logic  taken;	// set only by a taken branch
		tag_t  tag;
	} exec_result_t;

endpackage

`default_nettype wire

//--- design/op_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_consts.svh"

module op_queue (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              issue_valid,
	input  wire exec_pkg::exec_op_t issue_op,
	input  wire logic              pop,
	output logic                   head_valid,
	output exec_pkg::exec_op_t     head,
	output logic                   credit_return
);
	import exec_pkg::*;

	localparam int DEPTH = `EXEC_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	exec_op_t slots [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head = slots[rd_ptr];
	assign do_pop = pop && head_valid;
	assign credit_return = do_pop;	// one credit back per dispatch

	// upstream only issues with a credit, so a free slot always exists
	always_ff @(posedge clk) begin
		if (issue_valid)
			slots[wr_ptr] <= issue_op;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (issue_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({issue_valid, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
	input  wire exec_pkg::alu_op_t op,
	input  wire exec_pkg::word_t   a,
	input  wire exec_pkg::word_t   b,
	input  wire exec_pkg::shamt_t  shamt,
	input  wire exec_pkg::word_t   hi,
	input  wire exec_pkg::word_t   lo,
	output exec_pkg::word_t        y,
	output logic                   zero
);
	import exec_pkg::*;

	localparam int MSB = $bits(word_t) - 1;

	shamt_t var_sh;
	word_t diff;

	assign var_sh = b[$bits(shamt_t)-1:0];	// variable shifts use low bits of b
	assign diff = a + (~b + 1'b1);	// two's complement subtract

	always_comb begin
		case (op)
			OP_AND: y = a & b;
			OP_OR: y = a | b;
			OP_XOR: y = a ^ b;
			OP_ADD: y = a + b;
			OP_SUB: y = diff;
			OP_SLTU: y = word_t'(a < b);
			OP_SLT: begin
				// differing signs decide it, else magnitudes compare
				if (a[MSB] != b[MSB])
					y = word_t'(a[MSB]);
				else
					y = word_t'(a < b);
			end
			OP_LUI: y = b << 16;
			OP_SLL: y = a << shamt;
			OP_SRL: y = a >> shamt;
			OP_SRA: y = $signed(a) >>> shamt;	// sign fill
			OP_SLLV: y = a << var_sh;
			OP_SRLV: y = a >> var_sh;
			OP_SRAV: y = $signed(a) >>> var_sh;
			OP_MFHI: y = hi;
			OP_MFLO: y = lo;
			OP_BEQ,
			OP_BNE,
			OP_BGEZ,
			OP_BGTZ,
			OP_BLEZ,
			OP_BLTZ: y = diff;	// branches report a - b
			default: y = '0;	// muldiv results come from lo
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

//--- design/branch_compare.sv
`timescale 1ns/1ps
`default_nettype none

module branch_compare (
	input  wire exec_pkg::alu_op_t op,
	input  wire exec_pkg::word_t   a,
	input  wire exec_pkg::word_t   b,
	output logic                   taken
);
	import exec_pkg::*;

	logic a_neg;
	logic a_zero;

	assign a_neg = a[$bits(word_t)-1];	// signed view of a
	assign a_zero = (a == '0);

	always_comb begin
		case (op)
			OP_BEQ: taken = (a == b);
			OP_BNE: taken = (a != b);
			OP_BGEZ: taken = !a_neg;
			OP_BGTZ: taken = !a_neg && !a_zero;
			OP_BLEZ: taken = a_neg || a_zero;
			OP_BLTZ: taken = a_neg;
			default: taken = 1'b0;	// not a branch
		endcase
	end

endmodule

`default_nettype wire

//--- design/muldiv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_ctrl (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic start,
	input  wire logic last_step,
	output logic      load,
	output logic      step,
	output logic      md_busy,
	output logic      md_done
);
	import exec_pkg::*;

	muldiv_state_t state;
	muldiv_state_t state_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= MD_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			MD_IDLE: begin
				if (start)
					state_next = MD_RUN;
			end
			MD_RUN: begin
				if (last_step)
					state_next = MD_FINISH;
			end
			MD_FINISH: state_next = MD_IDLE;	// one result cycle
			default: state_next = MD_IDLE;
		endcase
	end

	assign load = (state == MD_IDLE) && start;
	assign step = (state == MD_RUN);
	assign md_busy = (state != MD_IDLE);	// holds the queue
	assign md_done = (state == MD_FINISH);

endmodule

`default_nettype wire

//--- design/muldiv_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_consts.svh"

module muldiv_counter (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic load,
	input  wire logic step,
	output logic      last_step
);
	localparam int STEPS = `EXEC_MULDIV_STEPS;
	localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count <= '0;
		else if (load)
			count <= CNT_W'(STEPS - 1);	// counts steps left after this one
		else if (step && count != '0)
			count <= count - 1'b1;
	end

	assign last_step = step && (count == '0);

endmodule

`default_nettype wire

//--- design/muldiv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_datapath (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            load,
	input  wire logic            step,
	input  wire logic            is_div,
	input  wire exec_pkg::word_t a,
	input  wire exec_pkg::word_t b,
	output exec_pkg::word_t      hi,
	output exec_pkg::word_t      lo
);
	import exec_pkg::*;

	localparam int XLEN = $bits(word_t);

	word_t operand;	// multiplicand or divisor
	logic div_mode;
	logic [XLEN:0] mul_sum;
	logic [XLEN:0] rem_shift;
	logic [XLEN:0] rem_diff;
	logic fits;

	// multiply adds b on a set low multiplier bit and shifts right
	assign mul_sum = {1'b0, hi} + (lo[0] ? {1'b0, operand} : '0);

	// divide brings in the next dividend bit and subtracts when the divisor fits
	assign rem_shift = {hi, lo[XLEN-1]};
	assign rem_diff = rem_shift - {1'b0, operand};
	assign fits = (rem_shift >= {1'b0, operand});

	always_ff @(posedge clk) begin
		if (load)
			operand <= b;
	end

	// lo starts as multiplier or dividend and ends as product low or quotient
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
			div_mode <= 1'b0;
		end else if (load) begin
			hi <= '0;
			lo <= a;
			div_mode <= is_div;
		end else if (step) begin
			if (div_mode) begin
				hi <= fits ? rem_diff[XLEN-1:0] : rem_shift[XLEN-1:0];
				lo <= {lo[XLEN-2:0], fits};	// quotient bit in
			end else begin
				hi <= mul_sum[XLEN:1];
				lo <= {mul_sum[0], lo[XLEN-1:1]};
			end
		end
	end

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               issue_valid,
	input  wire exec_pkg::exec_op_t issue_op,
	output logic                    credit_return,
	output logic                    res_valid,
	output exec_pkg::exec_result_t  res
);
	import exec_pkg::*;

	logic head_valid;
	exec_op_t head;
	logic pop;
	logic is_div;
	logic is_md;
	logic start;
	word_t alu_y;
	logic alu_zero;
	logic br_taken;
	word_t hi;
	word_t lo;
	logic load;
	logic step;
	logic last_step;
	logic md_busy;
	logic md_done;
	tag_t md_tag;	// tag of the multiply or divide in flight

	op_queue u_queue (
		.clk, .rst_n, .issue_valid, .issue_op, .pop,
		.head_valid, .head, .credit_return
	);

	assign is_div = (head.op == OP_DIVU);
	assign is_md = is_div || (head.op == OP_MULTU);
	assign pop = head_valid && !md_busy;	// queue stalls while muldiv runs
	assign start = pop && is_md;

	alu_core u_alu (
		.op(head.op), .a(head.a), .b(head.b), .shamt(head.shamt),
		.hi, .lo, .y(alu_y), .zero(alu_zero)
	);

	branch_compare u_branch (.op(head.op), .a(head.a), .b(head.b), .taken(br_taken));

	muldiv_ctrl u_md_ctrl (.clk, .rst_n, .start, .last_step, .load, .step, .md_busy, .md_done);

	muldiv_counter u_md_cnt (.clk, .rst_n, .load, .step, .last_step);

	muldiv_datapath u_md_dp (
		.clk, .rst_n, .load, .step, .is_div, .a(head.a), .b(head.b), .hi, .lo
	);

	always_ff @(posedge clk) begin
		if (start)
			md_tag <= head.tag;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= (pop && !is_md) || md_done;
	end

	// md_done only occurs while busy, so it never meets a single-cycle pop
	always_ff @(posedge clk) begin
		if (md_done)
			res <= '{value: lo, zero: (lo == '0), taken: 1'b0, tag: md_tag};
		else if (pop && !is_md)
			res <= '{value: alu_y, zero: alu_zero, taken: br_taken, tag: head.tag};
	end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);
	initial clk = 1'b0;
	always #(PERIOD_NS / 2) clk = ~clk;	// free running
endmodule

`default_nettype wire

//--- verification/exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_consts.svh"

module exec_unit_tb;
	import exec_pkg::*;

	localparam int DEPTH = `EXEC_QUEUE_DEPTH;
	localparam int TIMEOUT = 200;	// cycles per wait

	logic clk;
	logic rst_n;
	logic issue_valid;
	exec_op_t issue_op;
	logic credit_return;
	logic res_valid;
	exec_result_t res;
	exec_result_t expected_q[$];	// one entry per issued operation
	exec_result_t want;
	word_t model_hi = '0;
	word_t model_lo = '0;
	word_t r;
	tag_t next_tag = '0;
	int credits = DEPTH;	// upstream view of free slots
	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	int failed = 0;
	alu_op_t arith_ops[5] = '{OP_AND, OP_OR, OP_XOR, OP_ADD, OP_SUB};
	alu_op_t branch_ops[6] = '{OP_BEQ, OP_BNE, OP_BGEZ, OP_BGTZ, OP_BLEZ, OP_BLTZ};
	shamt_t shamts[3] = '{5'd0, 5'd31, 5'd13};

	tb_clock #(.PERIOD_NS(40)) u_clock (.clk);

	exec_unit i_dut (
		.clk, .rst_n, .issue_valid, .issue_op, .credit_return, .res_valid, .res
	);

	// models the execute rules with hi and lo kept in issue order
	function automatic exec_result_t expected_result(input exec_op_t o);
		exec_result_t e;
		e = '0;
		e.tag = o.tag;
		e.value = o.a - o.b;	// branch value unless overridden
		case (o.op)
			OP_AND: e.value = o.a & o.b;
			OP_OR: e.value = o.a | o.b;
			OP_XOR: e.value = o.a ^ o.b;
			OP_ADD: e.value = o.a + o.b;
			OP_SUB: e.value = o.a - o.b;
			OP_SLTU: e.value = word_t'(o.a < o.b);
			OP_SLT: e.value = word_t'($signed(o.a) < $signed(o.b));
			OP_LUI: e.value = o.b << 16;
			OP_SLL: e.value = o.a << o.shamt;
			OP_SRL: e.value = o.a >> o.shamt;
			OP_SRA: e.value = $signed(o.a) >>> o.shamt;
			OP_SLLV: e.value = o.a << o.b[4:0];
			OP_SRLV: e.value = o.a >> o.b[4:0];
			OP_SRAV: e.value = $signed(o.a) >>> o.b[4:0];
			OP_BEQ: e.taken = (o.a == o.b);
			OP_BNE: e.taken = (o.a != o.b);
			OP_BGEZ: e.taken = ($signed(o.a) >= 0);
			OP_BGTZ: e.taken = ($signed(o.a) > 0);
			OP_BLEZ: e.taken = ($signed(o.a) <= 0);
			OP_BLTZ: e.taken = ($signed(o.a) < 0);
			OP_MULTU: begin
				{model_hi, model_lo} = {32'b0, o.a} * {32'b0, o.b};
				e.value = model_lo;
			end
			OP_DIVU: begin
				model_lo = (o.b == '0) ? '1 : o.a / o.b;	// zero divisor gives all ones
				model_hi = (o.b == '0) ? o.a : o.a % o.b;
				e.value = model_lo;
			end
			OP_MFHI: e.value = model_hi;
			OP_MFLO: e.value = model_lo;
			default: e.value = '0;
		endcase
		e.zero = (e.value == '0);
		return e;
	endfunction

	task automatic mismatch(input string msg);
		errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic check_value(input word_t got, input word_t exp);
		if (got !== exp)
			mismatch($sformatf("value is %h, expected %h", got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			mismatch($sformatf("%s flag is %b, expected %b", what, got, exp));
	endtask

	task automatic check_tag(input tag_t got, input tag_t exp);
		if (got !== exp)
			mismatch($sformatf("tag is %0d, expected %0d", got, exp));
	endtask

	task automatic issue(input alu_op_t op, input word_t a, input word_t b, input shamt_t sh);
		int waited;
		waited = 0;
		while (credits == 0 && waited < TIMEOUT) begin	// stall until a slot frees
			@(posedge clk);
			#1;
			waited++;
		end
		if (credits == 0) begin
			$display("timeout, no credit came back to issue %s", op.name());
			errors++;
		end else begin
			issue_op = '{op: op, a: a, b: b, shamt: sh, tag: next_tag};
			expected_q.push_back(expected_result(issue_op));
			next_tag++;
			credits--;
			issue_valid = 1'b1;
			@(posedge clk);
			#1;
			issue_valid = 1'b0;
		end
	endtask

	task automatic end_test(input string name);
		int waited;
		waited = 0;
		while ((expected_q.size() != 0 || credits != DEPTH) && waited < TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (expected_q.size() != 0 || credits != DEPTH) begin
			$display("timeout in %s, %0d results and %0d credits never came back",
				name, expected_q.size(), DEPTH - credits);
			errors++;
		end
		tests++;
		if (errors != test_errors)
			failed++;
		$display("test %s done with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	always @(negedge clk) begin	// credit and result monitor
		if (rst_n && credit_return)
			credits++;
		if (credits > DEPTH) begin
			$display("a credit came back that was never spent");
			errors++;
			credits = DEPTH;
		end
		if (rst_n && res_valid) begin
			if (expected_q.size() == 0) begin
				$display("result with tag %0d appeared with nothing outstanding", res.tag);
				errors++;
			end else begin
				want = expected_q.pop_front();
				check_value(res.value, want.value);
				check_flag(res.zero, want.zero, "zero");
				check_flag(res.taken, want.taken, "taken");
				check_tag(res.tag, want.tag);	// issue order
			end
		end
	end

	initial begin
		void'($urandom(32'h3846525b));
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_op = '0;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;

		repeat (4) begin
			r = $urandom;
			foreach (arith_ops[k]) begin
				issue(arith_ops[k], r, $urandom, 5'd0);
				issue(arith_ops[k], r, r, 5'd0);	// equal operands
			end
			issue(OP_ADD, r, -r, 5'd0);	// sums to zero
			issue(OP_AND, r, ~r, 5'd0);
		end
		end_test("logic_arith");

		issue(OP_SLT, 32'hffff_fffb, 32'd3, 5'd0);
		issue(OP_SLT, 32'd3, 32'hffff_fffb, 5'd0);
		issue(OP_SLT, 32'hffff_fffe, 32'hffff_ffff, 5'd0);
		issue(OP_SLTU, 32'hffff_fffb, 32'd3, 5'd0);
		issue(OP_SLTU, 32'd3, 32'hffff_fffb, 5'd0);
		issue(OP_LUI, 32'd0, $urandom, 5'd0);
		r = 32'h8000_00f1;	// negative first, then positive
		repeat (2) begin
			foreach (shamts[s]) begin
				issue(OP_SLL, r, 32'd0, shamts[s]);
				issue(OP_SRL, r, 32'd0, shamts[s]);
				issue(OP_SRA, r, 32'd0, shamts[s]);
				issue(OP_SLLV, r, {27'h5a5a5a5, shamts[s]}, ~shamts[s]);	// b low bits count
				issue(OP_SRLV, r, {27'h5a5a5a5, shamts[s]}, ~shamts[s]);
				issue(OP_SRAV, r, {27'h5a5a5a5, shamts[s]}, ~shamts[s]);
			end
			r = ~r;
		end
		end_test("compare_shift");

		foreach (branch_ops[k]) begin
			issue(branch_ops[k], 32'd0, 32'd0, 5'd0);
			issue(branch_ops[k], 32'd7, 32'd7, 5'd0);
			issue(branch_ops[k], 32'd7, 32'd0, 5'd0);
			issue(branch_ops[k], 32'hffff_fff9, 32'd3, 5'd0);
		end
		end_test("branch");

		issue(OP_MULTU, $urandom, $urandom, 5'd0);
		issue(OP_MFHI, 32'd0, 32'd0, 5'd0);
		issue(OP_MFLO, 32'd0, 32'd0, 5'd0);
		issue(OP_XOR, $urandom, $urandom, 5'd0);	// queued behind the multiply
		issue(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 5'd0);
		issue(OP_MFHI, 32'd0, 32'd0, 5'd0);
		issue(OP_MFLO, 32'd0, 32'd0, 5'd0);
		end_test("multiply");

		issue(OP_DIVU, $urandom, $urandom >> 20, 5'd0);
		issue(OP_MFHI, 32'd0, 32'd0, 5'd0);
		issue(OP_MFLO, 32'd0, 32'd0, 5'd0);
		issue(OP_DIVU, 32'd3, 32'd9, 5'd0);	// quotient zero
		issue(OP_MFHI, 32'd0, 32'd0, 5'd0);
		issue(OP_DIVU, $urandom, 32'd0, 5'd0);
		issue(OP_MFHI, 32'd0, 32'd0, 5'd0);
		issue(OP_MFLO, 32'd0, 32'd0, 5'd0);
		end_test("divide");

		repeat (3) begin	// bursts run out of credits while the multiply runs
			issue(OP_MULTU, $urandom, $urandom, 5'd0);
			repeat (6)
				issue(OP_ADD, $urandom, $urandom, 5'd0);
		end
		end_test("credits");

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/exec_pkg.sv
design/op_queue.sv
design/alu_core.sv
design/branch_compare.sv
design/muldiv_ctrl.sv
design/muldiv_counter.sv
design/muldiv_datapath.sv
design/exec_unit.sv
verification/tb_clock.sv
verification/exec_unit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module exec_unit_tb -o exec_sim || exit 1
out=$(./obj_dir/exec_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "STATUS: PASS" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
